// ==== hw/cfo_tracker.sv ====
`timescale 1ns/100ps
`include "rx_config.svh"

module cfo_tracker (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     sample_valid_i,
    input  rx_sync_pkg::cfo_update_t cfo_update_i,
    input  rx_bus_pkg::bus_req_t     peer_req_i,
    input  logic                     req_valid_i,
    output rx_bus_pkg::bus_rsp_t     rsp_o,
    output logic                     rsp_valid_o
);

    rx_sync_pkg::cfo_mode_e        mode_q;
    logic signed [`RX_PHASE_W-1:0] acc_q;
    logic [`RX_PHASE_W-1:0]        phase_q;
    logic [`RX_OFFSET_W-1:0]       offset;
    logic                          is_read;
    rx_bus_pkg::bus_rsp_t          rsp_d;

    assign offset  = peer_req_i.addr[`RX_OFFSET_W-1:0];
    assign is_read = (peer_req_i.op == rx_bus_pkg::BUS_READ);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mode_q  <= rx_sync_pkg::CFO_AUTO;
            acc_q   <= '0;
            phase_q <= '0;
        end else begin
            if (req_valid_i && !is_read && offset == 'd0)
                mode_q <= rx_sync_pkg::cfo_mode_e'(peer_req_i.wdata[0]);
            if (mode_q == rx_sync_pkg::CFO_MANUAL) begin
                acc_q   <= '0;
                phase_q <= '0;
            end else begin
                // updates are relative, so subtract
                if (cfo_update_i.valid)
                    acc_q <= acc_q - cfo_update_i.inc;
                // phase steps with the old increment
                if (sample_valid_i)
                    phase_q <= phase_q + acc_q;
            end
        end
    end

    always_comb begin
        rsp_d.resp  = rx_bus_pkg::RESP_SLVERR;
        rsp_d.rdata = '0;
        case (offset)
            'd0: begin
                rsp_d.resp     = rx_bus_pkg::RESP_OKAY;
                rsp_d.rdata[0] = (mode_q == rx_sync_pkg::CFO_MANUAL);
            end
            'd1: if (is_read) begin
                rsp_d.resp  = rx_bus_pkg::RESP_OKAY;
                rsp_d.rdata = {{(`RX_DATA_W-`RX_PHASE_W){acc_q[`RX_PHASE_W-1]}}, acc_q};
            end
            'd2: if (is_read) begin
                rsp_d.resp                    = rx_bus_pkg::RESP_OKAY;
                rsp_d.rdata[`RX_PHASE_W-1:0] = phase_q;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= req_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i)
            rsp_o <= rsp_d;
    end

endmodule

// ==== hw/ctrl_bus_decoder.sv ====
`timescale 1ns/100ps
`include "rx_config.svh"

module ctrl_bus_decoder (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  rx_bus_pkg::bus_req_t bus_req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output rx_bus_pkg::bus_rsp_t bus_rsp_o,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output rx_bus_pkg::bus_req_t peer_req_o,
    output logic                 llr_req_valid_o,
    output logic                 cfo_req_valid_o,
    output logic                 sts_req_valid_o,
    input  rx_bus_pkg::bus_rsp_t llr_rsp_i,
    input  logic                 llr_rsp_valid_i,
    input  rx_bus_pkg::bus_rsp_t cfo_rsp_i,
    input  logic                 cfo_rsp_valid_i,
    input  rx_bus_pkg::bus_rsp_t sts_rsp_i,
    input  logic                 sts_rsp_valid_i
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_WAIT,
        DEC_HOLD
    } dec_state_e;

    dec_state_e            state_q;
    rx_bus_pkg::peer_sel_e sel_q;
    logic                  strobe_q;
    logic                  decerr_q;
    logic                  accept;
    logic                  peer_rsp_valid;
    rx_bus_pkg::bus_rsp_t  peer_rsp;

    assign req_ready_o = (state_q == DEC_IDLE);
    assign rsp_valid_o = (state_q == DEC_HOLD);
    assign accept      = req_valid_i && req_ready_o;

    assign llr_req_valid_o = strobe_q && (sel_q == rx_bus_pkg::PEER_LLR);
    assign cfo_req_valid_o = strobe_q && (sel_q == rx_bus_pkg::PEER_CFO);
    assign sts_req_valid_o = strobe_q && (sel_q == rx_bus_pkg::PEER_STATUS);

    // unmapped region answers in the same slot as a peer would
    always_comb begin
        peer_rsp_valid = llr_rsp_valid_i || cfo_rsp_valid_i || sts_rsp_valid_i || decerr_q;
        peer_rsp.resp  = rx_bus_pkg::RESP_DECERR;
        peer_rsp.rdata = '0;
        if (llr_rsp_valid_i)
            peer_rsp = llr_rsp_i;
        else if (cfo_rsp_valid_i)
            peer_rsp = cfo_rsp_i;
        else if (sts_rsp_valid_i)
            peer_rsp = sts_rsp_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q  <= DEC_IDLE;
            strobe_q <= 1'b0;
            decerr_q <= 1'b0;
        end else begin
            strobe_q <= accept;
            decerr_q <= strobe_q && (sel_q == rx_bus_pkg::PEER_NONE);
            case (state_q)
                DEC_IDLE: if (accept) state_q <= DEC_WAIT;
                DEC_WAIT: if (peer_rsp_valid) state_q <= DEC_HOLD;
                DEC_HOLD: if (rsp_ready_i) state_q <= DEC_IDLE;
                default:  state_q <= DEC_IDLE;
            endcase
        end
    end

    // peers only see their local offset
    always_ff @(posedge clk_i) begin
        if (accept) begin
            sel_q            <= rx_bus_pkg::peer_sel_e'(bus_req_i.addr[`RX_ADDR_W-1:`RX_OFFSET_W]);
            peer_req_o.op    <= bus_req_i.op;
            peer_req_o.addr  <= {{(`RX_ADDR_W-`RX_OFFSET_W){1'b0}},
                                 bus_req_i.addr[`RX_OFFSET_W-1:0]};
            peer_req_o.wdata <= bus_req_i.wdata;
        end
        if (state_q == DEC_WAIT && peer_rsp_valid)
            bus_rsp_o <= peer_rsp;
    end

    // ------------------------------------------------------------------------
    a_one_peer_rsp: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $onehot0({llr_rsp_valid_i, cfo_rsp_valid_i, sts_rsp_valid_i}));

    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (llr_rsp_valid_i || cfo_rsp_valid_i || sts_rsp_valid_i) |-> state_q == DEC_WAIT);

endmodule

// ==== hw/llr_capture_fifo.sv ====
`timescale 1ns/100ps
`include "rx_config.svh"

module llr_capture_fifo (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  rx_sync_pkg::llr_beat_t llr_i,
    input  rx_bus_pkg::bus_req_t   peer_req_i,
    input  logic                   req_valid_i,
    output rx_bus_pkg::bus_rsp_t   rsp_o,
    output logic                   rsp_valid_o
);

    localparam int PTR_W = $clog2(`RX_LLR_FIFO_DEPTH);
    localparam int LVL_W = PTR_W + 1;

    // entry is {last, data}
    logic [`RX_LLR_W:0]      mem [`RX_LLR_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [LVL_W-1:0]        level_q;
    logic                    overflow_q;
    logic [`RX_OFFSET_W-1:0] offset;
    logic                    is_read;
    logic                    empty;
    logic                    full;
    logic                    push;
    logic                    push_ok;
    logic                    pop;
    logic                    clear;
    rx_bus_pkg::bus_rsp_t    rsp_d;

    assign offset  = peer_req_i.addr[`RX_OFFSET_W-1:0];
    assign is_read = (peer_req_i.op == rx_bus_pkg::BUS_READ);
    assign empty   = (level_q == '0);
    assign full    = (level_q == LVL_W'(`RX_LLR_FIFO_DEPTH));
    assign push    = llr_i.valid && (llr_i.kind == rx_sync_pkg::LLR_PBCH);
    assign push_ok = push && !full && !clear;
    assign pop     = req_valid_i && is_read && (offset == 'd0) && !empty;
    assign clear   = req_valid_i && !is_read && (offset == 'd1);

    always_ff @(posedge clk_i) begin
        if (push_ok)
            mem[wr_ptr_q] <= {llr_i.last, llr_i.data};
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            level_q    <= '0;
            overflow_q <= 1'b0;
        end else if (clear) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            level_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // sticky until the host clears it
            if (push && full)
                overflow_q <= 1'b1;
            level_q <= level_q + LVL_W'(push_ok) - LVL_W'(pop);
        end
    end

    // ------------------------------------------------------------------------
    always_comb begin
        rsp_d.resp  = rx_bus_pkg::RESP_SLVERR;
        rsp_d.rdata = '0;
        if (offset == 'd0 && is_read && !empty) begin
            rsp_d.resp               = rx_bus_pkg::RESP_OKAY;
            rsp_d.rdata[`RX_LLR_W:0] = mem[rd_ptr_q];
        end else if (offset == 'd1) begin
            rsp_d.resp = rx_bus_pkg::RESP_OKAY;
            if (is_read) begin
                rsp_d.rdata[LVL_W-1:0]      = level_q;
                rsp_d.rdata[`RX_DATA_W-1] = overflow_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= req_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i)
            rsp_o <= rsp_d;
    end

    a_level_bound: assert property (@(posedge clk_i) disable iff (!reset_ni)
        level_q <= LVL_W'(`RX_LLR_FIFO_DEPTH));

endmodule

// ==== hw/rx_bus_pkg.sv ====
`include "rx_config.svh"

package rx_bus_pkg;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // same encodings as AXI xRESP
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } bus_resp_e;

    // top two address bits
    typedef enum logic [1:0] {
        PEER_LLR    = 2'd0,
        PEER_CFO    = 2'd1,
        PEER_STATUS = 2'd2,
        PEER_NONE   = 2'd3
    } peer_sel_e;

    typedef struct packed {
        bus_op_e                op;
        logic [`RX_ADDR_W-1:0] addr;
        logic [`RX_DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        bus_resp_e              resp;
        logic [`RX_DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

// ==== hw/rx_config.svh ====
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// register bus
`define RX_DATA_W 32
`define RX_ADDR_W 16

// low bits select a register inside a peer
`define RX_OFFSET_W 14

// LLR capture
`define RX_LLR_W 8
`define RX_LLR_FIFO_DEPTH 16

// DDS phase and CFO increment width
`define RX_PHASE_W 20

// cell-search results
`define RX_NID_W 10
`define RX_NID2_W 2
`define RX_IBAR_W 3

`endif

// ==== hw/rx_ctrl_top.sv ====
`timescale 1ns/100ps

module rx_ctrl_top (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  rx_bus_pkg::bus_req_t     bus_req_i,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    output rx_bus_pkg::bus_rsp_t     bus_rsp_o,
    output logic                     rsp_valid_o,
    input  logic                     rsp_ready_i,
    input  logic                     sample_valid_i,
    input  rx_sync_pkg::sync_event_t sync_event_i,
    input  rx_sync_pkg::cfo_update_t cfo_update_i,
    input  rx_sync_pkg::llr_beat_t   llr_i
);

    rx_bus_pkg::bus_req_t peer_req;
    rx_bus_pkg::bus_rsp_t llr_rsp;
    rx_bus_pkg::bus_rsp_t cfo_rsp;
    rx_bus_pkg::bus_rsp_t sts_rsp;
    logic                 llr_req_valid;
    logic                 cfo_req_valid;
    logic                 sts_req_valid;
    logic                 llr_rsp_valid;
    logic                 cfo_rsp_valid;
    logic                 sts_rsp_valid;

    ctrl_bus_decoder u_decoder (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .bus_req_i       (bus_req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .bus_rsp_o       (bus_rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .peer_req_o      (peer_req),
        .llr_req_valid_o (llr_req_valid),
        .cfo_req_valid_o (cfo_req_valid),
        .sts_req_valid_o (sts_req_valid),
        .llr_rsp_i       (llr_rsp),
        .llr_rsp_valid_i (llr_rsp_valid),
        .cfo_rsp_i       (cfo_rsp),
        .cfo_rsp_valid_i (cfo_rsp_valid),
        .sts_rsp_i       (sts_rsp),
        .sts_rsp_valid_i (sts_rsp_valid)
    );

    llr_capture_fifo u_llr_fifo (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .llr_i       (llr_i),
        .peer_req_i  (peer_req),
        .req_valid_i (llr_req_valid),
        .rsp_o       (llr_rsp),
        .rsp_valid_o (llr_rsp_valid)
    );

    cfo_tracker u_cfo (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .cfo_update_i   (cfo_update_i),
        .peer_req_i     (peer_req),
        .req_valid_i    (cfo_req_valid),
        .rsp_o          (cfo_rsp),
        .rsp_valid_o    (cfo_rsp_valid)
    );

    sync_status_regs u_status (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .sync_event_i   (sync_event_i),
        .peer_req_i     (peer_req),
        .req_valid_i    (sts_req_valid),
        .rsp_o          (sts_rsp),
        .rsp_valid_o    (sts_rsp_valid)
    );

endmodule

// ==== hw/rx_sync_pkg.sv ====
`include "rx_config.svh"

package rx_sync_pkg;

    // detector results, each with its own valid
    typedef struct packed {
        logic                  nid2_valid;
        logic [`RX_NID2_W-1:0] nid2;
        logic                  nid_valid;
        logic [`RX_NID_W-1:0]  nid;
        logic                  ibar_valid;
        logic [`RX_IBAR_W-1:0] ibar;
    } sync_event_t;

    // relative to the previous update
    typedef struct packed {
        logic                          valid;
        logic signed [`RX_PHASE_W-1:0] inc;
    } cfo_update_t;

    typedef enum logic [1:0] {
        LLR_OTHER = 2'd0,
        LLR_PBCH  = 2'd1,
        LLR_SSS   = 2'd2
    } llr_kind_e;

    typedef struct packed {
        logic                 valid;
        logic [`RX_LLR_W-1:0] data;
        llr_kind_e            kind;
        logic                 last;
    } llr_beat_t;

    typedef enum logic {
        CFO_AUTO   = 1'b0,
        CFO_MANUAL = 1'b1
    } cfo_mode_e;

endpackage

// ==== hw/sync_status_regs.sv ====
`timescale 1ns/100ps
`include "rx_config.svh"

module sync_status_regs (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     sample_valid_i,
    input  rx_sync_pkg::sync_event_t sync_event_i,
    input  rx_bus_pkg::bus_req_t     peer_req_i,
    input  logic                     req_valid_i,
    output rx_bus_pkg::bus_rsp_t     rsp_o,
    output logic                     rsp_valid_o
);

    logic [`RX_NID2_W-1:0]   nid2_q;
    logic [`RX_NID_W-1:0]    nid_q;
    logic [`RX_IBAR_W-1:0]   ibar_q;
    logic [`RX_DATA_W-1:0]   sample_cnt_q;
    logic [`RX_OFFSET_W-1:0] offset;
    logic                    is_read;
    rx_bus_pkg::bus_rsp_t    rsp_d;

    assign offset  = peer_req_i.addr[`RX_OFFSET_W-1:0];
    assign is_read = (peer_req_i.op == rx_bus_pkg::BUS_READ);

    // ------------------------------------------------------------------------
    // latched cell-search results
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            nid2_q <= '0;
            nid_q  <= '0;
            ibar_q <= '0;
        end else begin
            if (sync_event_i.nid2_valid)
                nid2_q <= sync_event_i.nid2;
            if (sync_event_i.nid_valid)
                nid_q <= sync_event_i.nid;
            if (sync_event_i.ibar_valid)
                ibar_q <= sync_event_i.ibar;
        end
    end

    // free running, wraps
    always_ff @(posedge clk_i) begin
        if (!reset_ni)
            sample_cnt_q <= '0;
        else if (sample_valid_i)
            sample_cnt_q <= sample_cnt_q + 1'b1;
    end

    // ------------------------------------------------------------------------
    // read only block, every write is rejected
    always_comb begin
        rsp_d.resp  = rx_bus_pkg::RESP_SLVERR;
        rsp_d.rdata = '0;
        if (is_read) begin
            rsp_d.resp = rx_bus_pkg::RESP_OKAY;
            case (offset)
                'd0: rsp_d.rdata[`RX_NID2_W-1:0] = nid2_q;
                'd1: rsp_d.rdata[`RX_NID_W-1:0]  = nid_q;
                'd2: rsp_d.rdata[`RX_IBAR_W-1:0] = ibar_q;
                'd3: rsp_d.rdata                 = sample_cnt_q;
                default: rsp_d.resp = rx_bus_pkg::RESP_SLVERR;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= req_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i)
            rsp_o <= rsp_d;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/rx_bus_pkg.sv
hw/rx_sync_pkg.sv
hw/ctrl_bus_decoder.sv
hw/llr_capture_fifo.sv
hw/cfo_tracker.sv
hw/sync_status_regs.sv
hw/rx_ctrl_top.sv
verif/rx_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run with Verilator, pass or fail comes from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module rx_ctrl_tb \
    -f list.f -o rx_ctrl_sim &&
    ./obj_dir/rx_ctrl_sim > "$LOG" 2>&1 ||
    echo "build or simulation returned an error"

cat "$LOG" 2>/dev/null
grep -qF '*** PASSED ***' "$LOG" && echo "result: pass" && exit 0 || echo "result: fail"
exit 1

// ==== verif/rx_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "rx_config.svh"

module rx_ctrl_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int BUS_TIMEOUT = 20;
    // watchdog allows ten times the roughly 1000 test cycles
    localparam int TEST_CYCLES = 1000;
    localparam int WATCHDOG_NS = 10 * TEST_CYCLES * CLK_PERIOD;

    logic                     clk_i;
    logic                     reset_ni;
    rx_bus_pkg::bus_req_t     bus_req_i;
    logic                     req_valid_i;
    logic                     req_ready_o;
    rx_bus_pkg::bus_rsp_t     bus_rsp_o;
    logic                     rsp_valid_o;
    logic                     rsp_ready_i;
    logic                     sample_valid_i;
    rx_sync_pkg::sync_event_t sync_event_i;
    rx_sync_pkg::cfo_update_t cfo_update_i;
    rx_sync_pkg::llr_beat_t   llr_i;

    // reference state with {nid2, nid, ibar} packed for the status latches
    logic [`RX_PHASE_W-1:0] acc_ref;
    logic [`RX_PHASE_W-1:0] phase_ref;
    logic                   manual_ref;
    logic [14:0]            status_ref;
    logic [31:0]            samples_ref;
    logic [`RX_LLR_W:0]     fifo_ref[$];
    logic                   overflow_ref;

    // checks waiting for the compare process
    string       chk_name_q[$];
    logic [63:0] chk_exp_q[$];
    logic [63:0] chk_act_q[$];
    int          err_count;
    int          check_count;
    int          test_count;
    int          test_err_start;
    int          force_hold;

    rx_ctrl_top dut (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .bus_req_i      (bus_req_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .bus_rsp_o      (bus_rsp_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .sample_valid_i (sample_valid_i),
        .sync_event_i   (sync_event_i),
        .cfo_update_i   (cfo_update_i),
        .llr_i          (llr_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // reference model

    function automatic logic [2*`RX_PHASE_W-1:0] cfo_ref(
        input logic [`RX_PHASE_W-1:0] acc,
        input logic [`RX_PHASE_W-1:0] phase,
        input rx_sync_pkg::cfo_update_t upd,
        input logic sample,
        input logic manual
    );
        logic [`RX_PHASE_W-1:0] acc_n;
        logic [`RX_PHASE_W-1:0] phase_n;
        acc_n   = acc;
        phase_n = phase;
        if (manual) begin
            acc_n   = '0;
            phase_n = '0;
        end else begin
            if (upd.valid)
                acc_n = acc - upd.inc;
            // phase uses acc from before this cycle's update
            if (sample)
                phase_n = phase + acc;
        end
        return {acc_n, phase_n};
    endfunction

    function automatic logic [14:0] status_latch(input logic [14:0] cur,
                                                 input rx_sync_pkg::sync_event_t ev);
        logic [14:0] nxt;
        nxt = cur;
        if (ev.nid2_valid)
            nxt[14:13] = ev.nid2;
        if (ev.nid_valid)
            nxt[12:3] = ev.nid;
        if (ev.ibar_valid)
            nxt[2:0] = ev.ibar;
        return nxt;
    endfunction

    function automatic logic llr_kept(input rx_sync_pkg::llr_beat_t beat);
        return beat.valid && (beat.kind == rx_sync_pkg::LLR_PBCH);
    endfunction

    function automatic logic [31:0] level_word();
        return {overflow_ref, 31'(fifo_ref.size())};
    endfunction

    // ------------------------------------------------------------------------
    // compare process

    task automatic expect_eq(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp);
        chk_act_q.push_back(act);
    endtask

    always @(posedge clk_i) begin
        while (chk_name_q.size() > 0) begin
            check_count++;
            if (chk_exp_q[0] !== chk_act_q[0]) begin
                $display("FAIL %s: expected 0x%0h, got 0x%0h",
                         chk_name_q[0], chk_exp_q[0], chk_act_q[0]);
                err_count++;
            end
            void'(chk_name_q.pop_front());
            void'(chk_exp_q.pop_front());
            void'(chk_act_q.pop_front());
        end
    end

    // ------------------------------------------------------------------------
    // stimulus

    task automatic idle_inputs();
        sample_valid_i = 1'b0;
        sync_event_i   = '0;
        cfo_update_i   = '0;
        llr_i          = '0;
    endtask

    task automatic drive_inputs(input int cycles, input bit use_cfo, input bit use_llr);
        logic [2*`RX_PHASE_W-1:0] cfo_next;
        logic [31:0]              rnd;
        repeat (cycles) begin
            @(negedge clk_i);
            rnd                = $urandom;
            sample_valid_i     = rnd[31];
            sync_event_i       = rnd[17:0];
            cfo_update_i.valid = use_cfo && rnd[18];
            cfo_update_i.inc   = `RX_PHASE_W'($urandom);
            llr_i.valid        = use_llr && rnd[19];
            llr_i.data         = rnd[27:20];
            llr_i.kind         = rx_sync_pkg::llr_kind_e'(2'($urandom_range(2, 0)));
            llr_i.last         = rnd[28];
            cfo_next  = cfo_ref(acc_ref, phase_ref, cfo_update_i, sample_valid_i, manual_ref);
            acc_ref   = cfo_next[2*`RX_PHASE_W-1:`RX_PHASE_W];
            phase_ref = cfo_next[`RX_PHASE_W-1:0];
            status_ref = status_latch(status_ref, sync_event_i);
            if (sample_valid_i)
                samples_ref++;
            if (llr_kept(llr_i)) begin
                if (fifo_ref.size() < `RX_LLR_FIFO_DEPTH)
                    fifo_ref.push_back({llr_i.last, llr_i.data});
                else
                    overflow_ref = 1'b1;
            end
        end
        @(negedge clk_i);
        idle_inputs();
    endtask

    task automatic bus_access(input rx_bus_pkg::bus_op_e op, input rx_bus_pkg::peer_sel_e peer,
                              input int offset, input logic [31:0] wdata,
                              output rx_bus_pkg::bus_rsp_t rsp);
        int hold;
        int waited;
        rsp  = '0;
        hold = (force_hold >= 0) ? force_hold : int'($urandom_range(3, 0));
        @(negedge clk_i);
        bus_req_i.op    = op;
        bus_req_i.addr  = {peer, `RX_OFFSET_W'(offset)};
        bus_req_i.wdata = wdata;
        req_valid_i     = 1'b1;
        waited          = 0;
        while (!req_ready_o && waited < BUS_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!req_ready_o) begin
            $display("request to address 0x%04h was never accepted", bus_req_i.addr);
            err_count++;
            req_valid_i = 1'b0;
            return;
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
        waited      = 0;
        while (!rsp_valid_o && waited < BUS_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!rsp_valid_o) begin
            $display("no response to address 0x%04h within %0d cycles",
                     bus_req_i.addr, BUS_TIMEOUT);
            err_count++;
            return;
        end
        expect_eq("rsp_valid_o latency", 64'd2, 64'(waited));
        rsp = bus_rsp_o;
        // response must hold while the host stalls
        repeat (hold) begin
            @(negedge clk_i);
            expect_eq("bus_rsp_o held", 64'(rsp), 64'(bus_rsp_o));
            expect_eq("rsp_valid_o held high", 64'd1, 64'(rsp_valid_o));
            expect_eq("req_ready_o held low", 64'd0, 64'(req_ready_o));
        end
        rsp_ready_i = 1'b1;
        @(negedge clk_i);
        rsp_ready_i = 1'b0;
        expect_eq("req_ready_o after handshake", 64'd1, 64'(req_ready_o));
        expect_eq("rsp_valid_o after handshake", 64'd0, 64'(rsp_valid_o));
    endtask

    task automatic expect_read(input string name, input rx_bus_pkg::peer_sel_e peer,
                               input int offset, input rx_bus_pkg::bus_resp_e exp_resp,
                               input logic [31:0] exp_data);
        rx_bus_pkg::bus_rsp_t rsp;
        bus_access(rx_bus_pkg::BUS_READ, peer, offset, '0, rsp);
        expect_eq($sformatf("bus_rsp_o.resp (%s)", name), 64'(exp_resp), 64'(rsp.resp));
        expect_eq($sformatf("bus_rsp_o.rdata (%s)", name), 64'(exp_data), 64'(rsp.rdata));
    endtask

    task automatic expect_write(input string name, input rx_bus_pkg::peer_sel_e peer,
                                input int offset, input logic [31:0] wdata,
                                input rx_bus_pkg::bus_resp_e exp_resp);
        rx_bus_pkg::bus_rsp_t rsp;
        bus_access(rx_bus_pkg::BUS_WRITE, peer, offset, wdata, rsp);
        expect_eq($sformatf("bus_rsp_o.resp (%s)", name), 64'(exp_resp), 64'(rsp.resp));
    endtask

    task automatic finish_test(input string name);
        // give the compare process time to drain
        repeat (2) @(negedge clk_i);
        test_count++;
        $display("test %0d %s done, %0d errors", test_count, name, err_count - test_err_start);
        test_err_start = err_count;
    endtask

    // ------------------------------------------------------------------------

    initial begin
        int n;
        void'($urandom(32'h8846_64e1));
        clk_i       = 1'b0;
        reset_ni    = 1'b0;
        bus_req_i   = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        idle_inputs();
        acc_ref        = '0;
        phase_ref      = '0;
        manual_ref     = 1'b0;
        status_ref     = '0;
        samples_ref    = '0;
        overflow_ref   = 1'b0;
        err_count      = 0;
        check_count    = 0;
        test_count     = 0;
        test_err_start = 0;
        force_hold     = -1;
        repeat (2) @(negedge clk_i);
        reset_ni = 1'b1;

        expect_eq("req_ready_o after reset", 64'd1, 64'(req_ready_o));
        expect_eq("rsp_valid_o after reset", 64'd0, 64'(rsp_valid_o));
        for (int i = 0; i < 4; i++)
            expect_read($sformatf("status %0d", i), rx_bus_pkg::PEER_STATUS, i,
                        rx_bus_pkg::RESP_OKAY, '0);
        expect_read("llr level", rx_bus_pkg::PEER_LLR, 1, rx_bus_pkg::RESP_OKAY, '0);
        expect_read("cfo mode", rx_bus_pkg::PEER_CFO, 0, rx_bus_pkg::RESP_OKAY, '0);
        expect_read("cfo acc", rx_bus_pkg::PEER_CFO, 1, rx_bus_pkg::RESP_OKAY, '0);
        expect_read("cfo phase", rx_bus_pkg::PEER_CFO, 2, rx_bus_pkg::RESP_OKAY, '0);
        finish_test("reset_values");

        drive_inputs(40, 1'b0, 1'b0);
        expect_read("nid2", rx_bus_pkg::PEER_STATUS, 0, rx_bus_pkg::RESP_OKAY,
                    32'(status_ref[14:13]));
        expect_read("nid", rx_bus_pkg::PEER_STATUS, 1, rx_bus_pkg::RESP_OKAY,
                    32'(status_ref[12:3]));
        expect_read("ibar", rx_bus_pkg::PEER_STATUS, 2, rx_bus_pkg::RESP_OKAY,
                    32'(status_ref[2:0]));
        expect_read("sample count", rx_bus_pkg::PEER_STATUS, 3, rx_bus_pkg::RESP_OKAY,
                    samples_ref);
        finish_test("status_latching");

        drive_inputs(60, 1'b1, 1'b0);
        expect_read("cfo acc", rx_bus_pkg::PEER_CFO, 1, rx_bus_pkg::RESP_OKAY,
                    {{(32-`RX_PHASE_W){acc_ref[`RX_PHASE_W-1]}}, acc_ref});
        expect_read("cfo phase", rx_bus_pkg::PEER_CFO, 2, rx_bus_pkg::RESP_OKAY,
                    32'(phase_ref));
        expect_write("cfo manual", rx_bus_pkg::PEER_CFO, 0, 32'd1, rx_bus_pkg::RESP_OKAY);
        manual_ref = 1'b1;
        acc_ref    = '0;
        phase_ref  = '0;
        expect_read("cfo mode", rx_bus_pkg::PEER_CFO, 0, rx_bus_pkg::RESP_OKAY, 32'd1);
        drive_inputs(20, 1'b1, 1'b0);
        expect_read("cfo acc manual", rx_bus_pkg::PEER_CFO, 1, rx_bus_pkg::RESP_OKAY, '0);
        expect_read("cfo phase manual", rx_bus_pkg::PEER_CFO, 2, rx_bus_pkg::RESP_OKAY, '0);
        expect_write("cfo auto", rx_bus_pkg::PEER_CFO, 0, 32'd0, rx_bus_pkg::RESP_OKAY);
        manual_ref = 1'b0;
        finish_test("cfo_tracking");

        // stay under the depth first and then force an overflow
        drive_inputs(12, 1'b0, 1'b1);
        expect_read("llr level", rx_bus_pkg::PEER_LLR, 1, rx_bus_pkg::RESP_OKAY, level_word());
        n = fifo_ref.size();
        for (int i = 0; i < n; i++)
            expect_read("llr pop", rx_bus_pkg::PEER_LLR, 0, rx_bus_pkg::RESP_OKAY,
                        32'(fifo_ref.pop_front()));
        expect_read("llr pop empty", rx_bus_pkg::PEER_LLR, 0, rx_bus_pkg::RESP_SLVERR, '0);
        while (fifo_ref.size() < `RX_LLR_FIFO_DEPTH || !overflow_ref)
            drive_inputs(4, 1'b0, 1'b1);
        expect_read("llr level full", rx_bus_pkg::PEER_LLR, 1, rx_bus_pkg::RESP_OKAY,
                    level_word());
        for (int i = 0; i < `RX_LLR_FIFO_DEPTH; i++)
            expect_read("llr pop", rx_bus_pkg::PEER_LLR, 0, rx_bus_pkg::RESP_OKAY,
                        32'(fifo_ref.pop_front()));
        drive_inputs(6, 1'b0, 1'b1);
        expect_read("llr level", rx_bus_pkg::PEER_LLR, 1, rx_bus_pkg::RESP_OKAY, level_word());
        expect_write("llr clear", rx_bus_pkg::PEER_LLR, 1, '0, rx_bus_pkg::RESP_OKAY);
        fifo_ref.delete();
        overflow_ref = 1'b0;
        expect_read("llr level cleared", rx_bus_pkg::PEER_LLR, 1, rx_bus_pkg::RESP_OKAY, '0);
        finish_test("llr_capture");

        expect_read("unmapped", rx_bus_pkg::PEER_NONE, 5, rx_bus_pkg::RESP_DECERR, '0);
        expect_write("unmapped write", rx_bus_pkg::PEER_NONE, 0, 32'hdead_beef,
                     rx_bus_pkg::RESP_DECERR);
        expect_write("status write", rx_bus_pkg::PEER_STATUS, 0, 32'(~status_ref[14:13]),
                     rx_bus_pkg::RESP_SLVERR);
        expect_read("nid2 after write", rx_bus_pkg::PEER_STATUS, 0, rx_bus_pkg::RESP_OKAY,
                    32'(status_ref[14:13]));
        expect_write("cfo acc write", rx_bus_pkg::PEER_CFO, 1, 32'h1, rx_bus_pkg::RESP_SLVERR);
        expect_read("cfo acc after write", rx_bus_pkg::PEER_CFO, 1, rx_bus_pkg::RESP_OKAY,
                    {{(32-`RX_PHASE_W){acc_ref[`RX_PHASE_W-1]}}, acc_ref});
        force_hold = 3;
        expect_read("cfo phase stalled", rx_bus_pkg::PEER_CFO, 2, rx_bus_pkg::RESP_OKAY,
                    32'(phase_ref));
        force_hold = -1;
        finish_test("errors_backpressure");

        repeat (2) @(negedge clk_i);
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
